// ==== bench/fifo_checker.sv ====
`timescale 1ns/1ns

module fifo_checker import fifo_geom_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  int                  test_id_i,
  input  logic                w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  input  logic                w_full_i,
  input  logic                r_en_i,
  input  logic [R_DATA_W-1:0] r_data_i,
  input  logic                r_empty_i,
  input  logic [LEVEL_W-1:0]  level_i,
  output int                  errors_o,
  output int                  tests_passed_o,
  output int                  tests_failed_o
);

  logic [W_DATA_W-1:0] model_q [$];  // bytes in write order
  int                  model_level = 0;
  logic                word_valid  = 1'b0;
  logic [R_DATA_W-1:0] last_word   = '0;
  int                  cur_test    = 0;
  int                  test_checks = 0;
  int                  test_errors = 0;
  int                  error_count = 0;
  int                  pass_count  = 0;
  int                  fail_count  = 0;

  assign errors_o       = error_count;
  assign tests_passed_o = pass_count;
  assign tests_failed_o = fail_count;

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    test_checks++;
    if (act_val !== exp_val) begin
      $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp_val, act_val);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %0d passed, %0d checks", cur_test, test_checks);
      pass_count++;
    end else begin
      $display("test %0d failed, %0d of %0d checks wrong", cur_test, test_errors, test_checks);
      fail_count++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // inputs and registered outputs settle by mid-cycle
  always @(negedge clk_i) begin
    logic                model_full;
    logic                model_empty;
    logic                wr_ok;
    logic                rd_ok;
    logic [R_DATA_W-1:0] word;

    if (test_id_i != cur_test) begin
      if (cur_test != 0) begin
        report_test();
      end
      cur_test = test_id_i;
    end

    if (rst_i) begin
      model_q.delete();
      model_level = 0;
      word_valid  = 1'b0;
    end else begin
      model_full  = model_level > FIFO_SIZE - W_INCR;
      model_empty = model_level < R_INCR;

      compare_value("level_o", 32'(model_level), 32'(level_i));
      compare_value("w_full_o", 32'(model_full), 32'(w_full_i));
      compare_value("r_empty_o", 32'(model_empty), 32'(r_empty_i));
      if (word_valid) begin
        compare_value("r_data_o", last_word, r_data_i);  // also covers the hold
      end

      // what the coming edge accepts
      wr_ok = w_en_i && !model_full;
      rd_ok = r_en_i && !model_empty;

      if (rd_ok) begin
        for (int i = 0; i < R_DATA_W / W_DATA_W; i++) begin
          word[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();  // oldest byte lowest
        end
        last_word   = word;
        word_valid  = 1'b1;
        model_level = model_level - R_INCR;
      end
      if (wr_ok) begin
        model_q.push_back(w_data_i);
        model_level = model_level + W_INCR;
      end
    end
  end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ns

module tb_top import fifo_geom_pkg::*; ();

  typedef struct packed {
    int                  id;
    logic                wr;
    logic                rnd;   // random byte instead of data
    logic [W_DATA_W-1:0] data;
    logic                rd;
    int                  count;
  } row_t;

  logic                clk = 1'b0;
  logic                rst;
  logic                w_en;
  logic [W_DATA_W-1:0] w_data;
  logic                w_full;
  logic                r_en;
  logic [R_DATA_W-1:0] r_data;
  logic                r_empty;
  logic [LEVEL_W-1:0]  level;
  int                  test_id;
  int                  errors;
  int                  tests_passed;
  int                  tests_failed;
  int                  timeouts = 0;
  row_t                stim_rows [$];

  always #2 clk = ~clk;

  fifo_top dut_i (
    .clk_i     (clk),
    .rst_i     (rst),
    .w_en_i    (w_en),
    .w_data_i  (w_data),
    .w_full_o  (w_full),
    .r_en_i    (r_en),
    .r_data_o  (r_data),
    .r_empty_o (r_empty),
    .level_o   (level)
  );

  fifo_checker check_i (
    .clk_i          (clk),
    .rst_i          (rst),
    .test_id_i      (test_id),
    .w_en_i         (w_en),
    .w_data_i       (w_data),
    .w_full_i       (w_full),
    .r_en_i         (r_en),
    .r_data_i       (r_data),
    .r_empty_i      (r_empty),
    .level_i        (level),
    .errors_o       (errors),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed)
  );

  function automatic void add_row(input int id, input logic wr, input logic rnd,
                                  input logic [W_DATA_W-1:0] data, input logic rd,
                                  input int count);
    row_t r;
    r.id    = id;
    r.wr    = wr;
    r.rnd   = rnd;
    r.data  = data;
    r.rd    = rd;
    r.count = count;
    stim_rows.push_back(r);
  endfunction

  task automatic build_table();
    add_row(1, 1'b0, 1'b0, 8'h00, 1'b1, 3);  // reads while empty
    // empty holds until the fourth byte
    add_row(2, 1'b1, 1'b0, 8'h11, 1'b0, 1);
    add_row(2, 1'b1, 1'b0, 8'h22, 1'b0, 1);
    add_row(2, 1'b1, 1'b0, 8'h33, 1'b0, 1);
    add_row(2, 1'b1, 1'b0, 8'h44, 1'b0, 1);
    add_row(3, 1'b1, 1'b0, 8'h55, 1'b0, 1);
    add_row(3, 1'b1, 1'b0, 8'h66, 1'b0, 1);
    add_row(3, 1'b1, 1'b0, 8'h77, 1'b0, 1);
    add_row(3, 1'b1, 1'b0, 8'h88, 1'b0, 1);
    add_row(3, 1'b0, 1'b0, 8'h00, 1'b1, 2);
    // fill up and then try writes that must be dropped
    add_row(4, 1'b1, 1'b1, 8'h00, 1'b0, 64);
    add_row(4, 1'b1, 1'b0, 8'hee, 1'b0, 2);
    add_row(5, 1'b0, 1'b0, 8'h00, 1'b1, 1);
    add_row(5, 1'b1, 1'b1, 8'h00, 1'b1, 4);  // level 60 down to 48
    add_row(6, 1'b0, 1'b0, 8'h00, 1'b1, 14);  // two reads past empty
  endtask

  task automatic wait_for_empty(input int max_cycles);
    int n;
    n = 0;
    while (!r_empty && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!r_empty) begin
      $display("timeout: FIFO still not empty after %0d cycles", max_cycles);
      timeouts++;
    end
  endtask

  task automatic wait_for_reports(input int expected, input int max_cycles);
    int n;
    n = 0;
    while (tests_passed + tests_failed < expected && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (tests_passed + tests_failed < expected) begin
      $display("timeout: only %0d of %0d test reports arrived",
               tests_passed + tests_failed, expected);
      timeouts++;
    end
  endtask

  initial begin
    row_t row;
    int   num_tests;

    rst     = 1'b1;
    w_en    = 1'b0;
    w_data  = '0;
    r_en    = 1'b0;
    test_id = 0;
    void'($urandom(32'hb4335930));

    build_table();
    num_tests = stim_rows[stim_rows.size()-1].id;

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    foreach (stim_rows[i]) begin
      row = stim_rows[i];
      for (int n = 0; n < row.count; n++) begin
        @(posedge clk);
        #1;
        test_id = row.id;
        w_en    = row.wr;
        w_data  = row.rnd ? W_DATA_W'($urandom) : row.data;
        r_en    = row.rd;
      end
    end

    @(posedge clk);
    #1;
    w_en = 1'b0;
    r_en = 1'b0;
    wait_for_empty(20);

    @(posedge clk);
    #1;
    test_id = 0;  // closes the last test
    wait_for_reports(num_tests, 10);

    $display("tests passed %0d, failed %0d, value errors %0d, timeouts %0d",
             tests_passed, tests_failed, errors, timeouts);
    if (errors == 0 && timeouts == 0 && tests_failed == 0 && tests_passed == num_tests) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== logic/asym_converter.sv ====
`timescale 1ns/1ns

module asym_converter import fifo_geom_pkg::*, ext_mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  w_en_i,
  input  logic [W_ADDR_W-1:0]   w_addr_i,
  input  logic [W_DATA_W-1:0]   w_data_i,
  input  logic                  r_en_i,
  input  logic [R_ADDR_W-1:0]   r_addr_i,
  output logic [R_DATA_W-1:0]   r_data_o,
  output logic [MEM_LANES-1:0]  mem_w_lane_en_o,
  output logic [ROW_ADDR_W-1:0] mem_w_row_o,
  output logic [MEM_ROW_W-1:0]  mem_w_data_o,
  output logic                  mem_r_en_o,
  output logic [ROW_ADDR_W-1:0] mem_r_row_o,
  input  logic [MEM_ROW_W-1:0]  mem_r_data_i
);

  // write side
  if (W_DATA_W < R_DATA_W) begin : g_w_narrow
    logic [LANE_SEL_W-1:0] w_lane;

    assign w_lane      = w_addr_i[LANE_SEL_W-1:0];
    assign mem_w_row_o = w_addr_i[W_ADDR_W-1:LANE_SEL_W];

    // one lane per byte with the data copied to all lanes
    always_comb begin
      mem_w_lane_en_o = MEM_LANES'(w_en_i) << w_lane;
    end
    assign mem_w_data_o = {MEM_LANES{w_data_i}};
  end else begin : g_w_wide
    assign mem_w_row_o     = w_addr_i;
    assign mem_w_lane_en_o = {MEM_LANES{w_en_i}};  // whole row at once
    assign mem_w_data_o    = w_data_i;
  end

  assign mem_r_en_o = r_en_i;

  // read side
  if (R_DATA_W < W_DATA_W) begin : g_r_narrow
    logic [LANE_SEL_W-1:0] r_lane_q;

    assign mem_r_row_o = r_addr_i[R_ADDR_W-1:LANE_SEL_W];

    // lane select lines up with the registered row
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        r_lane_q <= '0;
      end else if (r_en_i) begin
        r_lane_q <= r_addr_i[LANE_SEL_W-1:0];
      end
    end

    assign r_data_o = mem_r_data_i[r_lane_q*LANE_W +: LANE_W];
  end else begin : g_r_wide
    assign mem_r_row_o = r_addr_i;
    assign r_data_o    = mem_r_data_i;  // lane 0 holds the oldest byte
  end

endmodule

// ==== logic/asym_fifo_sync.sv ====
`timescale 1ns/1ns

module asym_fifo_sync import fifo_geom_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          w_en_i,
  input  logic [W_DATA_W-1:0]           w_data_i,
  output logic                          w_full_o,
  input  logic                          r_en_i,
  output logic [R_DATA_W-1:0]           r_data_o,
  output logic                          r_empty_o,
  output logic [LEVEL_W-1:0]            level_o,
  output logic [RATIO-1:0]              mem_w_lane_en_o,
  output logic [ADDR_W-ADDR_W_DIFF-1:0] mem_w_row_o,
  output logic [MAXDATA_W-1:0]          mem_w_data_o,
  output logic                          mem_r_en_o,
  output logic [ADDR_W-ADDR_W_DIFF-1:0] mem_r_row_o,
  input  logic [MAXDATA_W-1:0]          mem_r_data_i
);

  logic                w_en_int;
  logic                r_en_int;
  logic [W_ADDR_W-1:0] w_addr;
  logic [R_ADDR_W-1:0] r_addr;
  logic [LEVEL_W-1:0]  level_q;
  logic [LEVEL_W-1:0]  level_nxt;
  logic                w_full_nxt;
  logic                r_empty_nxt;

  // requests dropped while full or empty
  assign w_en_int = w_en_i & ~w_full_o;
  assign r_en_int = r_en_i & ~r_empty_o;

  // address counters wrap naturally
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_addr <= '0;
    end else if (w_en_int) begin
      w_addr <= w_addr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_addr <= '0;
    end else if (r_en_int) begin
      r_addr <= r_addr + 1'b1;
    end
  end

  // level in narrow units
  always_comb begin
    level_nxt = level_q;
    if (w_en_int) begin
      level_nxt = level_nxt + LEVEL_W'(W_INCR);
    end
    if (r_en_int) begin
      level_nxt = level_nxt - LEVEL_W'(R_INCR);
    end
  end

  // flags from the next level so they track the counter exactly
  assign r_empty_nxt = level_nxt < LEVEL_W'(R_INCR);
  assign w_full_nxt  = level_nxt > LEVEL_W'(FIFO_SIZE - W_INCR);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      level_q   <= '0;
      w_full_o  <= 1'b0;
      r_empty_o <= 1'b1;
    end else begin
      level_q   <= level_nxt;
      w_full_o  <= w_full_nxt;
      r_empty_o <= r_empty_nxt;
    end
  end

  assign level_o = level_q;

  asym_converter conv_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .w_en_i          (w_en_int),
    .w_addr_i        (w_addr),
    .w_data_i        (w_data_i),
    .r_en_i          (r_en_int),
    .r_addr_i        (r_addr),
    .r_data_o        (r_data_o),
    .mem_w_lane_en_o (mem_w_lane_en_o),
    .mem_w_row_o     (mem_w_row_o),
    .mem_w_data_o    (mem_w_data_o),
    .mem_r_en_o      (mem_r_en_o),
    .mem_r_row_o     (mem_r_row_o),
    .mem_r_data_i    (mem_r_data_i)
  );

endmodule

// ==== logic/ext_mem_pkg.sv ====
package ext_mem_pkg;

  // memory is built as lanes of the narrow port width
  localparam int MEM_LANES  = 4;
  localparam int LANE_W     = 8;

  localparam int ROW_ADDR_W = 4;  // 16 rows
  localparam int LANE_SEL_W = 2;

  localparam int MEM_ROW_W  = MEM_LANES * LANE_W;

endpackage

// ==== logic/fifo_geom_pkg.sv ====
package fifo_geom_pkg;

  // port widths
  localparam int W_DATA_W = 8;   // bytes in
  localparam int R_DATA_W = 32;  // words out

  localparam int ADDR_W = 6;  // counted in narrow units

  localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
  localparam int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;

  localparam int RATIO       = MAXDATA_W / MINDATA_W;
  localparam int ADDR_W_DIFF = $clog2(RATIO);

  // the wide side addresses whole rows
  localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? ADDR_W - ADDR_W_DIFF : ADDR_W;
  localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? ADDR_W - ADDR_W_DIFF : ADDR_W;

  // level steps per access, in narrow units
  localparam int W_INCR = (W_DATA_W > R_DATA_W) ? RATIO : 1;
  localparam int R_INCR = (R_DATA_W > W_DATA_W) ? RATIO : 1;

  localparam int FIFO_SIZE = 2 ** ADDR_W;
  localparam int LEVEL_W   = ADDR_W + 1;  // must hold FIFO_SIZE itself

endpackage

// ==== logic/fifo_top.sv ====
`timescale 1ns/1ns

module fifo_top import fifo_geom_pkg::*, ext_mem_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  output logic                w_full_o,
  input  logic                r_en_i,
  output logic [R_DATA_W-1:0] r_data_o,
  output logic                r_empty_o,
  output logic [LEVEL_W-1:0]  level_o
);

  // memory side wires
  logic [MEM_LANES-1:0]  mem_w_lane_en;
  logic [ROW_ADDR_W-1:0] mem_w_row;
  logic [MEM_ROW_W-1:0]  mem_w_data;
  logic                  mem_r_en;
  logic [ROW_ADDR_W-1:0] mem_r_row;
  logic [MEM_ROW_W-1:0]  mem_r_data;

  asym_fifo_sync fifo_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .w_en_i          (w_en_i),
    .w_data_i        (w_data_i),
    .w_full_o        (w_full_o),
    .r_en_i          (r_en_i),
    .r_data_o        (r_data_o),
    .r_empty_o       (r_empty_o),
    .level_o         (level_o),
    .mem_w_lane_en_o (mem_w_lane_en),
    .mem_w_row_o     (mem_w_row),
    .mem_w_data_o    (mem_w_data),
    .mem_r_en_o      (mem_r_en),
    .mem_r_row_o     (mem_r_row),
    .mem_r_data_i    (mem_r_data)
  );

  lane_ram_2p ram_i (
    .clk_i       (clk_i),
    .w_lane_en_i (mem_w_lane_en),
    .w_row_i     (mem_w_row),
    .w_data_i    (mem_w_data),
    .r_en_i      (mem_r_en),
    .r_row_i     (mem_r_row),
    .r_data_o    (mem_r_data)
  );

endmodule

// ==== logic/lane_ram_2p.sv ====
`timescale 1ns/1ns

module lane_ram_2p import ext_mem_pkg::*; (
  input  logic                  clk_i,
  input  logic [MEM_LANES-1:0]  w_lane_en_i,
  input  logic [ROW_ADDR_W-1:0] w_row_i,
  input  logic [MEM_ROW_W-1:0]  w_data_i,
  input  logic                  r_en_i,
  input  logic [ROW_ADDR_W-1:0] r_row_i,
  output logic [MEM_ROW_W-1:0]  r_data_o
);

  logic [MEM_ROW_W-1:0] mem [2**ROW_ADDR_W];

  // byte-lane writes
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MEM_LANES; i++) begin
      if (w_lane_en_i[i]) begin
        mem[w_row_i][i*LANE_W +: LANE_W] <= w_data_i[i*LANE_W +: LANE_W];
      end
    end
  end

  // registered read that holds between reads
  always_ff @(posedge clk_i) begin
    if (r_en_i) begin
      r_data_o <= mem[r_row_i];
    end
  end

endmodule

// ==== project.f ====
logic/fifo_geom_pkg.sv
logic/ext_mem_pkg.sv
logic/lane_ram_2p.sv
logic/asym_converter.sv
logic/asym_fifo_sync.sv
logic/fifo_top.sv
bench/fifo_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tb_top -f project.f

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
